// ==== src/acq_pkg.sv ====
package acq_pkg;

    ////////////////////////////////////////
    // Sample widths and frame framing
    ////////////////////////////////////////

    localparam int ADC_WIDTH    = 14;     // Raw offset-binary sample from the ADC
    localparam int SAMPLE_WIDTH = 16;     // Stored two's complement word

    localparam logic [3:0] FRAME_TAG = 4'hA;    // Upper nibble of every frame header

    ////////////////////////////////////////
    // Command byte
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_NOP       = 2'd0,
        OP_SET_DECIM = 2'd1,
        OP_CAPTURE   = 2'd2,
        OP_CLEAR     = 2'd3
    } cmd_op_t;

    // Configuration reading of the byte, used by OP_SET_DECIM
    typedef struct packed {
        cmd_op_t    op;
        logic [5:0] decim;
    } cmd_cfg_t;

    // Channel reading of the byte, used by OP_CAPTURE and OP_CLEAR
    typedef struct packed {
        cmd_op_t    op;
        logic [5:0] mask;
    } cmd_chan_t;

    typedef union packed {
        cmd_cfg_t  cfg;
        cmd_chan_t chan;
    } cmd_word_t;

endpackage

// ==== src/command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder
    import acq_pkg::*;
#(
    parameter int NUM_CH = 4
) (
    input  logic              sys_clock,
    input  logic              i_rst_n,
    input  cmd_word_t         i_cmd_byte,
    input  logic              i_cmd_strobe,
    output logic [5:0]        o_decim,
    output logic [NUM_CH-1:0] o_capture,
    output logic [NUM_CH-1:0] o_clear
);

    ////////////////////////////////////////
    // Byte decode
    ////////////////////////////////////////

    cmd_op_t           op;
    logic [NUM_CH-1:0] mask_sel;
    logic [5:0]        decim_field;

    // Both views share the opcode bits, so the opcode picks the view
    assign op          = i_cmd_byte.cfg.op;
    assign decim_field = i_cmd_byte.cfg.decim;
    assign mask_sel    = i_cmd_byte.chan.mask[NUM_CH-1:0];    // Bits above NUM_CH are ignored

    logic set_decim;
    logic do_capture;
    logic do_clear;

    always_comb begin
        set_decim  = 1'b0;
        do_capture = 1'b0;
        do_clear   = 1'b0;
        if (i_cmd_strobe) begin
            case (op)
                OP_SET_DECIM: set_decim  = 1'b1;
                OP_CAPTURE:   do_capture = 1'b1;
                OP_CLEAR:     do_clear   = 1'b1;
                default:      ;    // NOP leaves everything alone
            endcase
        end
    end

    ////////////////////////////////////////
    // Registered outputs
    ////////////////////////////////////////

    always_ff @(posedge sys_clock) begin
        if (!i_rst_n) begin
            o_decim   <= '0;
            o_capture <= '0;
            o_clear   <= '0;
        end else begin
            // Pulses last a single cycle unless a new command arrives
            o_capture <= do_capture ? mask_sel : '0;
            o_clear   <= do_clear ? mask_sel : '0;
            if (set_decim) begin
                o_decim <= decim_field;    // Ratio holds until the next SET_DECIM
            end
        end
    end

endmodule

// ==== src/sample_capture.sv ====
`timescale 1ns/1ps

module sample_capture
    import acq_pkg::*;
#(
    parameter int MEM_DEPTH = 16
) (
    input  logic                    sys_clock,
    input  logic                    i_rst_n,
    input  logic [ADC_WIDTH-1:0]    i_adc_data,
    input  logic                    i_adc_strobe,
    input  logic [5:0]              i_decim,
    input  logic                    i_capture,
    input  logic                    i_clear,
    input  logic                    i_read,
    output logic [SAMPLE_WIDTH-1:0] o_rd_data,
    output logic                    o_full,
    output logic                    o_busy
);

    localparam int AW = $clog2(MEM_DEPTH);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_FILL = 2'd1;
    localparam logic [1:0] ST_FULL = 2'd2;

    localparam logic [AW-1:0] LAST_ADDR = AW'(MEM_DEPTH - 1);

    logic [1:0]              state;
    logic [5:0]              dcnt;
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [SAMPLE_WIDTH-1:0] mem [MEM_DEPTH];

    ////////////////////////////////////////
    // Conversion
    ////////////////////////////////////////

    logic [ADC_WIDTH-1:0]    flipped;
    logic [SAMPLE_WIDTH-1:0] converted;

    // Offset binary becomes two's complement once the MSB is inverted
    assign flipped   = {~i_adc_data[ADC_WIDTH-1], i_adc_data[ADC_WIDTH-2:0]};
    assign converted = {{(SAMPLE_WIDTH - ADC_WIDTH){flipped[ADC_WIDTH-1]}}, flipped};

    logic keep;
    logic wr_en;
    logic rd_en;

    assign keep  = (state == ST_FILL) && i_adc_strobe && (dcnt == 6'd0);
    assign wr_en = keep && !i_clear;
    assign rd_en = (state == ST_FULL) && i_read && !i_clear;

    ////////////////////////////////////////
    // Controller
    ////////////////////////////////////////

    always_ff @(posedge sys_clock) begin
        if (!i_rst_n) begin
            state  <= ST_IDLE;
            dcnt   <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_clear) begin
            // A clear empties the buffer whatever the channel is doing
            state  <= ST_IDLE;
            dcnt   <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_capture) begin
                        state  <= ST_FILL;
                        dcnt   <= '0;    // First strobe after arming is always kept
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                    end
                end
                ST_FILL: begin
                    if (i_adc_strobe) begin
                        if (keep) begin
                            dcnt   <= i_decim;
                            wr_ptr <= wr_ptr + 1'b1;
                            if (wr_ptr == LAST_ADDR) begin
                                state <= ST_FULL;
                            end
                        end else begin
                            dcnt <= dcnt - 1'b1;
                        end
                    end
                end
                ST_FULL: begin
                    if (rd_en) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        if (rd_ptr == LAST_ADDR) begin
                            state <= ST_IDLE;    // Last word popped, buffer is free again
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Word memory
    ////////////////////////////////////////

    always_ff @(posedge sys_clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= converted;
        end
    end

    assign o_rd_data = mem[rd_ptr];    // Serializer sees the word at the read pointer
    assign o_full    = (state == ST_FULL);
    assign o_busy    = (state != ST_IDLE);

endmodule

// ==== src/frame_serializer.sv ====
`timescale 1ns/1ps

module frame_serializer
    import acq_pkg::*;
#(
    parameter int NUM_CH    = 4,
    parameter int MEM_DEPTH = 16
) (
    input  logic                           sys_clock,
    input  logic                           i_rst_n,
    input  logic [NUM_CH-1:0]              i_full,
    input  logic [NUM_CH*SAMPLE_WIDTH-1:0] i_rd_data,
    input  logic                           i_tx_ready,
    output logic [NUM_CH-1:0]              o_read,
    output logic [7:0]                     o_tx_byte,
    output logic                           o_tx_strobe
);

    // Phase 0 is the header, odd phases carry low bytes and even ones high bytes
    localparam int PW = $clog2(2 * MEM_DEPTH + 1);

    localparam logic [PW-1:0] LAST_PHASE = PW'(2 * MEM_DEPTH);

    logic          active;
    logic [3:0]    sel;
    logic [PW-1:0] phase;

    ////////////////////////////////////////
    // Lowest full channel
    ////////////////////////////////////////

    logic       any_full;
    logic [3:0] pick;

    always_comb begin
        any_full = 1'b0;
        pick     = '0;
        for (int k = NUM_CH - 1; k >= 0; k--) begin    // Walk downwards so channel 0 wins
            if (i_full[k]) begin
                any_full = 1'b1;
                pick     = 4'(k);
            end
        end
    end

    ////////////////////////////////////////
    // Byte selection
    ////////////////////////////////////////

    logic [SAMPLE_WIDTH-1:0] word;
    logic                    send;
    logic                    high_byte;

    always_comb begin
        word = '0;
        for (int k = 0; k < NUM_CH; k++) begin
            if (sel == 4'(k)) begin
                word = i_rd_data[k*SAMPLE_WIDTH +: SAMPLE_WIDTH];
            end
        end
    end

    assign send      = active && i_tx_ready;
    assign high_byte = (phase != '0) && !phase[0];

    always_comb begin
        if (phase == '0) begin
            o_tx_byte = {FRAME_TAG, sel};
        end else if (phase[0]) begin
            o_tx_byte = word[7:0];
        end else begin
            o_tx_byte = word[15:8];
        end
    end

    assign o_tx_strobe = send;
    assign o_read      = (send && high_byte) ? (NUM_CH'(1) << sel) : '0;    // Pops the word

    ////////////////////////////////////////
    // Frame sequencing
    ////////////////////////////////////////

    always_ff @(posedge sys_clock) begin
        if (!i_rst_n) begin
            active <= 1'b0;
            sel    <= '0;
            phase  <= '0;
        end else if (!active) begin
            if (any_full) begin
                active <= 1'b1;
                sel    <= pick;
                phase  <= '0;
            end
        end else if (i_tx_ready) begin
            // Without ready the byte and its position simply hold
            if (phase == LAST_PHASE) begin
                active <= 1'b0;
                phase  <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

endmodule

// ==== src/acq_top.sv ====
`timescale 1ns/1ps

module acq_top
    import acq_pkg::*;
#(
    parameter int NUM_CH    = 4,    // Up to 6 channels fit the command mask
    parameter int MEM_DEPTH = 16    // Must be a power of two
) (
    input  logic                        sys_clock,
    input  logic                        i_rst_n,
    input  cmd_word_t                   i_cmd_byte,
    input  logic                        i_cmd_strobe,
    input  logic [NUM_CH*ADC_WIDTH-1:0] i_adc_data,
    input  logic                        i_adc_strobe,
    input  logic                        i_tx_ready,
    output logic [7:0]                  o_tx_byte,
    output logic                        o_tx_strobe,
    output logic [NUM_CH-1:0]           o_chan_busy
);

    logic [5:0]                     decim;
    logic [NUM_CH-1:0]              capture;
    logic [NUM_CH-1:0]              clear;
    logic [NUM_CH-1:0]              full;
    logic [NUM_CH-1:0]              read;
    logic [NUM_CH*SAMPLE_WIDTH-1:0] rd_data;

    ////////////////////////////////////////
    // Command path
    ////////////////////////////////////////

    command_decoder #(
        .NUM_CH       (NUM_CH)
    ) u_decoder (
        .sys_clock    (sys_clock),
        .i_rst_n      (i_rst_n),
        .i_cmd_byte   (i_cmd_byte),
        .i_cmd_strobe (i_cmd_strobe),
        .o_decim      (decim),
        .o_capture    (capture),
        .o_clear      (clear)
    );

    ////////////////////////////////////////
    // Capture channels
    ////////////////////////////////////////

    for (genvar k = 0; k < NUM_CH; k++) begin : g_ch
        sample_capture #(
            .MEM_DEPTH    (MEM_DEPTH)
        ) u_capture (
            .sys_clock    (sys_clock),
            .i_rst_n      (i_rst_n),
            .i_adc_data   (i_adc_data[k*ADC_WIDTH +: ADC_WIDTH]),
            .i_adc_strobe (i_adc_strobe),
            .i_decim      (decim),
            .i_capture    (capture[k]),
            .i_clear      (clear[k]),
            .i_read       (read[k]),
            .o_rd_data    (rd_data[k*SAMPLE_WIDTH +: SAMPLE_WIDTH]),
            .o_full       (full[k]),
            .o_busy       (o_chan_busy[k])
        );
    end

    ////////////////////////////////////////
    // Output stream
    ////////////////////////////////////////

    frame_serializer #(
        .NUM_CH      (NUM_CH),
        .MEM_DEPTH   (MEM_DEPTH)
    ) u_serializer (
        .sys_clock   (sys_clock),
        .i_rst_n     (i_rst_n),
        .i_full      (full),
        .i_rd_data   (rd_data),
        .i_tx_ready  (i_tx_ready),
        .o_read      (read),
        .o_tx_byte   (o_tx_byte),
        .o_tx_strobe (o_tx_strobe)
    );

endmodule

// ==== verification/acq_chk.sv ====
`timescale 1ns/1ps

module acq_chk #(
    parameter int NUM_CH = 4
) (
    input logic              sys_clock,
    input logic              i_rst_n,
    input logic              i_tx_ready,
    input logic [NUM_CH-1:0] o_read,
    input logic              o_tx_strobe
);

    // A byte only leaves when the transmitter can take it
    a_strobe_ready: assert property (@(posedge sys_clock) disable iff (!i_rst_n)
        o_tx_strobe |-> i_tx_ready)
        else $error("o_tx_strobe high while i_tx_ready is low");

    a_read_onehot: assert property (@(posedge sys_clock) disable iff (!i_rst_n)
        $onehot0(o_read))
        else $error("o_read pops more than one channel");

    // Words are popped only with the strobe of their high byte
    a_read_strobe: assert property (@(posedge sys_clock) disable iff (!i_rst_n)
        (o_read != '0) |-> o_tx_strobe)
        else $error("o_read high without o_tx_strobe");

    a_quiet_reset: assert property (@(posedge sys_clock)
        !i_rst_n |=> !o_tx_strobe)
        else $error("o_tx_strobe high in the cycle after reset");

endmodule

bind frame_serializer acq_chk #(
    .NUM_CH      (NUM_CH)
) u_chk (
    .sys_clock   (sys_clock),
    .i_rst_n     (i_rst_n),
    .i_tx_ready  (i_tx_ready),
    .o_read      (o_read),
    .o_tx_strobe (o_tx_strobe)
);

// ==== verification/acq_tb.sv ====
`timescale 1ns/1ps

module acq_tb
    import acq_pkg::*;
;

    localparam int NUM_CH    = 4;
    localparam int MEM_DEPTH = 16;
    localparam int TIMEOUT   = 4 * 4 * (MEM_DEPTH * 64 + 40);    // Cycles before the run is cut

    logic                        sys_clock;
    logic                        i_rst_n;
    logic [7:0]                  i_cmd_byte;
    logic                        i_cmd_strobe;
    logic [NUM_CH*ADC_WIDTH-1:0] i_adc_data;
    logic                        i_adc_strobe;
    logic                        i_tx_ready;
    logic [7:0]                  o_tx_byte;
    logic                        o_tx_strobe;
    logic [NUM_CH-1:0]           o_chan_busy;

    logic [31:0]             rng;
    int                      errors;
    int                      cycles;
    logic [7:0]              rx_q [$];    // Bytes seen on the output
    logic [7:0]              exp_q [$];   // Bytes the model predicts
    logic [SAMPLE_WIDTH-1:0] exp_words [NUM_CH][MEM_DEPTH];

    acq_top #(
        .NUM_CH       (NUM_CH),
        .MEM_DEPTH    (MEM_DEPTH)
    ) uut (
        .sys_clock    (sys_clock),
        .i_rst_n      (i_rst_n),
        .i_cmd_byte   (i_cmd_byte),
        .i_cmd_strobe (i_cmd_strobe),
        .i_adc_data   (i_adc_data),
        .i_adc_strobe (i_adc_strobe),
        .i_tx_ready   (i_tx_ready),
        .o_tx_byte    (o_tx_byte),
        .o_tx_strobe  (o_tx_strobe),
        .o_chan_busy  (o_chan_busy)
    );

    initial begin
        sys_clock = 1'b0;
        forever #50 sys_clock = ~sys_clock;
    end

    ////////////////////////////////////////
    // Monitor and watchdog
    ////////////////////////////////////////

    always @(posedge sys_clock) begin
        if (i_rst_n && o_tx_strobe) begin
            rx_q.push_back(o_tx_byte);
        end
    end

    always @(posedge sys_clock) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("errors: %0d", errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // An offset-binary code is the signed value plus half of the code range
    function automatic logic [SAMPLE_WIDTH-1:0] to_sample(input logic [13:0] raw);
        int value;
        value = int'(raw) - 8192;
        return value[SAMPLE_WIDTH-1:0];
    endfunction

    function automatic logic [7:0] make_cmd(input cmd_op_t op, input logic [5:0] field);
        return {op, field};
    endfunction

    function automatic void push_frame(input int ch);
        exp_q.push_back({4'hA, 4'(ch)});
        for (int w = 0; w < MEM_DEPTH; w++) begin
            exp_q.push_back(exp_words[ch][w][7:0]);     // Low byte goes first
            exp_q.push_back(exp_words[ch][w][15:8]);
        end
    endfunction

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    // Sampling may start three cycles after the command byte
    task automatic send_cmd(input logic [7:0] b);
        i_cmd_byte   = b;
        i_cmd_strobe = 1'b1;
        @(negedge sys_clock);
        i_cmd_strobe = 1'b0;
        repeat (2) @(negedge sys_clock);
    endtask

    task automatic feed_samples(input logic [NUM_CH-1:0] mask, input logic [5:0] decim,
                                input int gap, input int n_keep);
        int idx;
        int kept;
        idx  = 0;
        kept = 0;
        while (kept < n_keep) begin
            for (int k = 0; k < NUM_CH; k++) begin
                rng = xorshift32(rng);
                i_adc_data[k*ADC_WIDTH +: ADC_WIDTH] = rng[ADC_WIDTH-1:0];
            end
            i_adc_strobe = 1'b1;
            if (idx % (int'(decim) + 1) == 0) begin    // First strobe, then every (d+1)-th
                for (int k = 0; k < NUM_CH; k++) begin
                    if (mask[k]) begin
                        exp_words[k][kept] = to_sample(i_adc_data[k*ADC_WIDTH +: ADC_WIDTH]);
                    end
                end
                kept++;
            end
            idx++;
            @(negedge sys_clock);
            i_adc_strobe = 1'b0;
            repeat (gap - 1) @(negedge sys_clock);
        end
    endtask

    task automatic wait_bytes(input int n, input bit jitter);
        while (rx_q.size() < n) begin
            @(negedge sys_clock);
            if (jitter) begin
                rng        = xorshift32(rng);
                i_tx_ready = rng[0];    // Transmitter stalls about half the time
            end
        end
        i_tx_ready = 1'b1;
    endtask

    task automatic check_busy(input logic [NUM_CH-1:0] expected, input string name);
        if (o_chan_busy !== expected) begin
            errors++;
            $display("mismatch o_chan_busy in %s: got 0x%h, expected 0x%h",
                     name, o_chan_busy, expected);
        end
    endtask

    task automatic compare_stream(input string name);
        int n;
        if (rx_q.size() != exp_q.size()) begin
            errors++;
            $display("%s: received %0d bytes but expected %0d", name, rx_q.size(), exp_q.size());
        end
        n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            if (rx_q[i] !== exp_q[i]) begin
                errors++;
                $display("mismatch o_tx_byte in %s at byte %0d: got 0x%h, expected 0x%h",
                         name, i, rx_q[i], exp_q[i]);
            end
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic capture_one(input int ch, input logic [5:0] decim, input int gap,
                               input bit jitter, input string name);
        rx_q.delete();
        exp_q.delete();
        send_cmd(make_cmd(OP_SET_DECIM, decim));
        send_cmd(make_cmd(OP_CAPTURE, 6'(1 << ch)));
        check_busy(4'(1 << ch), name);
        feed_samples(4'(1 << ch), decim, gap, MEM_DEPTH);
        push_frame(ch);
        wait_bytes(exp_q.size(), jitter);
        repeat (4) @(negedge sys_clock);    // Any extra byte would show up here
        compare_stream(name);
        check_busy(4'b0000, name);
    endtask

    task automatic multi_channel();
        rx_q.delete();
        exp_q.delete();
        send_cmd(make_cmd(OP_SET_DECIM, 6'd1));
        send_cmd(make_cmd(OP_CAPTURE, 6'b001011));
        check_busy(4'b1011, "multi fill");
        feed_samples(4'b1011, 6'd1, 1, MEM_DEPTH);
        push_frame(0);
        push_frame(1);
        push_frame(3);
        wait_bytes(1 * (1 + 2 * MEM_DEPTH), 1'b0);
        check_busy(4'b1010, "multi after ch0");
        wait_bytes(2 * (1 + 2 * MEM_DEPTH), 1'b0);
        check_busy(4'b1000, "multi after ch1");
        wait_bytes(3 * (1 + 2 * MEM_DEPTH), 1'b0);
        check_busy(4'b0000, "multi after ch3");
        repeat (4) @(negedge sys_clock);
        compare_stream("multi");
    endtask

    task automatic clear_and_ignore();
        rx_q.delete();
        send_cmd(make_cmd(OP_SET_DECIM, 6'd2));
        send_cmd(make_cmd(OP_CAPTURE, 6'b000001));
        feed_samples(4'b0001, 6'd2, 1, 5);    // Stops well short of a full buffer
        check_busy(4'b0001, "clear fill");
        send_cmd(make_cmd(OP_NOP, 6'h3f));
        check_busy(4'b0001, "clear nop");
        send_cmd(make_cmd(OP_CAPTURE, 6'b000001));
        check_busy(4'b0001, "clear recapture");
        send_cmd(make_cmd(OP_CLEAR, 6'b000001));
        check_busy(4'b0000, "clear done");
        feed_samples(4'b0000, 6'd2, 1, MEM_DEPTH);
        repeat (40) @(negedge sys_clock);
        if (rx_q.size() != 0) begin
            errors++;
            $display("clear: %0d bytes were sent from a cleared channel", rx_q.size());
        end
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_cmd_byte   = '0;
        i_cmd_strobe = 1'b0;
        i_adc_data   = '0;
        i_adc_strobe = 1'b0;
        i_tx_ready   = 1'b1;
        rng          = 32'd3;
        errors       = 0;
        cycles       = 0;
        repeat (10) @(negedge sys_clock);
        i_rst_n = 1'b1;
        @(negedge sys_clock);
        check_busy(4'b0000, "reset");
        if (o_tx_strobe !== 1'b0) begin
            errors++;
            $display("mismatch o_tx_strobe after reset: got 0x%h, expected 0x0", o_tx_strobe);
        end
        capture_one(1, 6'd0, 1, 1'b0, "single");
        capture_one(2, 6'd3, 2, 1'b0, "decim");
        multi_channel();
        capture_one(1, 6'd0, 1, 1'b1, "backpressure");
        clear_and_ignore();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/acq_pkg.sv
src/command_decoder.sv
src/sample_capture.sv
src/frame_serializer.sv
src/acq_top.sv
verification/acq_chk.sv
verification/acq_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = acq_tb
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
